// File: common/controlBus.sv
`timescale 1ns/1ps
`default_nettype none

interface controlBus import microPkg::*; ();

    // datapath controls
    logic pcInc;
    logic pcLoad;
    logic branchZero;
    logic irLoad;
    logic marFromImm;
    logic memWrite;
    logic regWrite;
    microPkg::regSource regSource;
    microPkg::aluOp aluOp;
    logic outStrobe;
    logic halt;

    // sequencing controls
    microPkg::seqMode seqMode;
    microState nextState;

    // microstore side, drives every field
    modport store (
        output pcInc, pcLoad, branchZero, irLoad, marFromImm, memWrite, regWrite,
        output regSource, aluOp, outStrobe, halt, seqMode, nextState
    );

    modport path (
        input pcInc, pcLoad, branchZero, irLoad, marFromImm, memWrite, regWrite,
        input regSource, aluOp, outStrobe, halt
    );

    modport seq (input seqMode, nextState);

endinterface

`default_nettype wire

// File: common/microPkg.sv
`default_nettype none

package microPkg;

    // default sizes, overridden from the top level
    parameter int DEFAULT_MEM_DEPTH = 256;
    parameter int DEFAULT_REG_COUNT = 4;

    // data path widths
    typedef logic [15:0] dataWord;
    typedef logic [7:0]  memAddress;
    typedef logic [1:0]  regIndex;

    // instruction bits 15..12, codes 14 and 15 undefined (run as NOP)
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDI  = 4'd1,
        OP_MOV  = 4'd2,
        OP_ADD  = 4'd3,
        OP_SUB  = 4'd4,
        OP_AND  = 4'd5,
        OP_OR   = 4'd6,
        OP_XOR  = 4'd7,
        OP_LD   = 4'd8,
        OP_ST   = 4'd9,
        OP_BEQZ = 4'd10,
        OP_JMP  = 4'd11,
        OP_OUT  = 4'd12,
        OP_HALT = 4'd13
    } opcode;

    // micro-states, FETCH0 doubles as the reset state
    typedef enum logic [6:0] {
        FETCH0   = 7'd0,
        FETCH1   = 7'd1,
        DECODE   = 7'd2,
        EXEC_LDI = 7'd3,
        EXEC_MOV = 7'd4,
        EXEC_ALU = 7'd5,
        LOAD0    = 7'd6,
        LOAD1    = 7'd7,
        STORE0   = 7'd8,
        BRANCH   = 7'd9,
        JUMP     = 7'd10,
        OUTPUT   = 7'd11,
        HALTED   = 7'd12
    } microState;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5
    } aluOp;

    // how the sequencer picks its next state
    typedef enum logic [2:0] {
        SEQ_NEXT     = 3'd0,
        SEQ_DISPATCH = 3'd1,
        SEQ_FETCH    = 3'd2,
        SEQ_HOLD     = 3'd3
    } seqMode;

    // register file write source
    typedef enum logic [1:0] {
        SRC_ALU = 2'd0,
        SRC_IMM = 2'd1,
        SRC_MEM = 2'd2,
        SRC_RS  = 2'd3
    } regSource;

    // 45-bit control word, 24 bits in use, the rest padding
    typedef struct packed {
        logic        pcInc;
        logic        pcLoad;
        logic        branchZero;
        logic        irLoad;
        logic        marFromImm;
        logic        memWrite;
        logic        regWrite;
        regSource    regSource;
        aluOp        aluOp;
        logic        outStrobe;
        logic        halt;
        seqMode      seqMode;
        microState   nextState;
        logic [20:0] reserved;
    } microWord;

endpackage

`default_nettype wire

// File: control/microSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module microSequencer import microPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  opcode     instrOpcode,
    controlBus.seq    bus,
    output microState currentState
);

    microState dispatchState;
    microState stateNext;

    // decode jump table
    // undefined codes fall through to FETCH0 like NOP
    always_comb begin
        case (instrOpcode)
            OP_LDI: dispatchState = EXEC_LDI;
            OP_MOV: dispatchState = EXEC_MOV;
            OP_ADD,
            OP_SUB,
            OP_AND,
            OP_OR,
            OP_XOR: dispatchState = EXEC_ALU;
            OP_LD: dispatchState = LOAD0;
            OP_ST: dispatchState = STORE0;
            OP_BEQZ: dispatchState = BRANCH;
            OP_JMP: dispatchState = JUMP;
            OP_OUT: dispatchState = OUTPUT;
            OP_HALT: dispatchState = HALTED;
            default: dispatchState = FETCH0;
        endcase
    end

    // next state per sequencing mode
    always_comb begin
        case (bus.seqMode)
            // explicit successor from the control word
            SEQ_NEXT: stateNext = bus.nextState;
            SEQ_DISPATCH: stateNext = dispatchState;
            // end of instruction
            SEQ_FETCH: stateNext = FETCH0;
            // parked, only reset leaves
            SEQ_HOLD: stateNext = currentState;
            default: stateNext = FETCH0;
        endcase
    end

    // micro-state register
    always_ff @(posedge clk) begin
        if (reset) begin
            currentState <= FETCH0;
        end else begin
            currentState <= stateNext;
        end
    end

endmodule

`default_nettype wire

// File: control/microstore.sv
`timescale 1ns/1ps
`default_nettype none

module microstore import microPkg::*; (
    input  microState  currentState,
    controlBus.store   bus
);

    // fetch step one, address from pc, then on to FETCH1
    localparam microWord FETCH0_WORD = '{
        pcInc:      1'b0,
        pcLoad:     1'b0,
        branchZero: 1'b0,
        irLoad:     1'b0,
        marFromImm: 1'b0,
        memWrite:   1'b0,
        regWrite:   1'b0,
        regSource:  SRC_ALU,
        aluOp:      ALU_PASS,
        outStrobe:  1'b0,
        halt:       1'b0,
        seqMode:    SEQ_NEXT,
        nextState:  FETCH1,
        reserved:   21'd0
    };

    microWord word;

    // control ROM, one word per micro-state
    always_comb begin
        word = '0;
        case (currentState)
            FETCH0: word = FETCH0_WORD;
            FETCH1: begin
                // latch instruction, bump pc
                word.irLoad = 1'b1;
                word.pcInc = 1'b1;
                word.seqMode = SEQ_NEXT;
                word.nextState = DECODE;
            end
            DECODE: word.seqMode = SEQ_DISPATCH;
            EXEC_LDI: begin
                word.regWrite = 1'b1;
                word.regSource = SRC_IMM;
                word.seqMode = SEQ_FETCH;
            end
            EXEC_MOV: begin
                word.regWrite = 1'b1;
                word.regSource = SRC_RS;
                word.seqMode = SEQ_FETCH;
            end
            EXEC_ALU: begin
                // PASS here lets the opcode choose the operation
                word.regWrite = 1'b1;
                word.regSource = SRC_ALU;
                word.aluOp = ALU_PASS;
                word.seqMode = SEQ_FETCH;
            end
            LOAD0: begin
                // address settles from imm
                word.marFromImm = 1'b1;
                word.seqMode = SEQ_NEXT;
                word.nextState = LOAD1;
            end
            LOAD1: begin
                word.marFromImm = 1'b1;
                word.regWrite = 1'b1;
                word.regSource = SRC_MEM;
                word.seqMode = SEQ_FETCH;
            end
            STORE0: begin
                word.marFromImm = 1'b1;
                word.memWrite = 1'b1;
                word.seqMode = SEQ_FETCH;
            end
            BRANCH: begin
                word.branchZero = 1'b1;
                word.seqMode = SEQ_FETCH;
            end
            JUMP: begin
                word.pcLoad = 1'b1;
                word.seqMode = SEQ_FETCH;
            end
            OUTPUT: begin
                word.outStrobe = 1'b1;
                word.seqMode = SEQ_FETCH;
            end
            HALTED: begin
                word.halt = 1'b1;
                word.seqMode = SEQ_HOLD;
            end
            // unknown state behaves like a fresh fetch
            default: word = FETCH0_WORD;
        endcase
    end

    // fan the word out onto the bus
    assign bus.pcInc = word.pcInc;
    assign bus.pcLoad = word.pcLoad;
    assign bus.branchZero = word.branchZero;
    assign bus.irLoad = word.irLoad;
    assign bus.marFromImm = word.marFromImm;
    assign bus.memWrite = word.memWrite;
    assign bus.regWrite = word.regWrite;
    assign bus.regSource = word.regSource;
    assign bus.aluOp = word.aluOp;
    assign bus.outStrobe = word.outStrobe;
    assign bus.halt = word.halt;
    assign bus.seqMode = word.seqMode;
    assign bus.nextState = word.nextState;

endmodule

`default_nettype wire

// File: filelist.f
common/microPkg.sv
common/controlBus.sv
control/microSequencer.sv
control/microstore.sv
source/datapath.sv
source/mainMemory.sv
source/microCpu.sv
verification/microCpuTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module microCpuTb -f filelist.f -o microCpuSim \
    && ./obj_dir/microCpuSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "Testbench passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: source/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import microPkg::*; #(
    parameter int REG_COUNT = DEFAULT_REG_COUNT
) (
    input  logic      clk,
    input  logic      reset,
    controlBus.path   bus,
    input  dataWord   memReadData,
    output memAddress memAddr,
    output dataWord   memWriteData,
    output logic      memWriteEnable,
    output opcode     instrOpcode,
    output dataWord   outData,
    output logic      outValid,
    output logic      halted
);

    memAddress pc;
    dataWord   ir;
    dataWord   regFile [REG_COUNT];
    regIndex   rdIdx;
    regIndex   rsIdx;
    memAddress imm;
    dataWord   rdValue;
    dataWord   rsValue;
    aluOp      aluSel;
    dataWord   aluResult;
    dataWord   regWriteData;
    logic      rdIsZero;

    // ALU operation implied by an instruction
    function automatic aluOp opcodeAlu(input opcode op);
        case (op)
            OP_ADD: return ALU_ADD;
            OP_SUB: return ALU_SUB;
            OP_AND: return ALU_AND;
            OP_OR: return ALU_OR;
            OP_XOR: return ALU_XOR;
            default: return ALU_PASS;
        endcase
    endfunction

    // 16-bit ALU, wraps on add and sub
    function automatic dataWord aluCompute(input aluOp op, input dataWord a, input dataWord b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR: return a | b;
            ALU_XOR: return a ^ b;
            default: return b;
        endcase
    endfunction

    // instruction fields
    assign instrOpcode = opcode'(ir[15:12]);
    assign rdIdx = ir[11:10];
    assign rsIdx = ir[9:8];
    assign imm = ir[7:0];

    assign rdValue = regFile[rdIdx];
    assign rsValue = regFile[rsIdx];
    assign rdIsZero = (rdValue == '0);

    // control word PASS defers to the opcode
    assign aluSel = (bus.aluOp == ALU_PASS) ? opcodeAlu(instrOpcode) : bus.aluOp;
    assign aluResult = aluCompute(aluSel, rdValue, rsValue);

    always_comb begin
        case (bus.regSource)
            SRC_IMM: regWriteData = {8'd0, imm};
            SRC_MEM: regWriteData = memReadData;
            SRC_RS: regWriteData = rsValue;
            default: regWriteData = aluResult;
        endcase
    end

    // memory side, store data always comes from rd
    assign memAddr = bus.marFromImm ? imm : pc;
    assign memWriteData = rdValue;
    assign memWriteEnable = bus.memWrite;

    // program counter, jump beats branch beats increment
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (bus.pcLoad) begin
            pc <= imm;
        end else if (bus.branchZero && rdIsZero) begin
            pc <= imm;
        end else if (bus.pcInc) begin
            pc <= pc + 8'd1;
        end
    end

    // instruction register, clears to NOP
    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (bus.irLoad) begin
            ir <= memReadData;
        end
    end

    // register file
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (bus.regWrite) begin
            regFile[rdIdx] <= regWriteData;
        end
    end

    // output strobe and sticky halt level
    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            halted <= 1'b0;
        end else begin
            outValid <= bus.outStrobe;
            if (bus.halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.outStrobe) begin
            outData <= rdValue;
        end
    end

endmodule

`default_nettype wire

// File: source/mainMemory.sv
`timescale 1ns/1ps
`default_nettype none

module mainMemory import microPkg::*; #(
    parameter int MEM_DEPTH = DEFAULT_MEM_DEPTH
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      loadEnable,
    input  memAddress loadAddress,
    input  dataWord   loadData,
    input  memAddress address,
    input  dataWord   writeData,
    input  logic      writeEnable,
    output dataWord   readData
);

    // unified program and data store
    dataWord mem [MEM_DEPTH];

    // write port belongs to the loader while reset is held
    always_ff @(posedge clk) begin
        if (reset) begin
            if (loadEnable) begin
                mem[loadAddress] <= loadData;
            end
        end else if (writeEnable) begin
            mem[address] <= writeData;
        end
    end

    // asynchronous read
    assign readData = mem[address];

endmodule

`default_nettype wire

// File: source/microCpu.sv
`timescale 1ns/1ps
`default_nettype none

module microCpu import microPkg::*; #(
    parameter int MEM_DEPTH = DEFAULT_MEM_DEPTH,
    parameter int REG_COUNT = DEFAULT_REG_COUNT
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      loadEnable,
    input  memAddress loadAddress,
    input  dataWord   loadData,
    output dataWord   outData,
    output logic      outValid,
    output logic      halted
);

    microState currentState;
    opcode     instrOpcode;
    memAddress memAddr;
    dataWord   memWriteData;
    logic      memWriteEnable;
    dataWord   memReadData;

    // microword fields from store to sequencer and datapath
    controlBus ctrlBus ();

    microSequencer microSequencer_inst (
        .clk          (clk),
        .reset        (reset),
        .instrOpcode  (instrOpcode),
        .bus          (ctrlBus.seq),
        .currentState (currentState)
    );

    microstore microstore_inst (
        .currentState (currentState),
        .bus          (ctrlBus.store)
    );

    datapath #(
        .REG_COUNT (REG_COUNT)
    ) datapath_inst (
        .clk            (clk),
        .reset          (reset),
        .bus            (ctrlBus.path),
        .memReadData    (memReadData),
        .memAddr        (memAddr),
        .memWriteData   (memWriteData),
        .memWriteEnable (memWriteEnable),
        .instrOpcode    (instrOpcode),
        .outData        (outData),
        .outValid       (outValid),
        .halted         (halted)
    );

    mainMemory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) mainMemory_inst (
        .clk         (clk),
        .reset       (reset),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .address     (memAddr),
        .writeData   (memWriteData),
        .writeEnable (memWriteEnable),
        .readData    (memReadData)
    );

endmodule

`default_nettype wire

// File: verification/microCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module microCpuTb import microPkg::*; ();

    localparam int MEM_DEPTH = 256;
    localparam int REG_COUNT = 4;
    // model gives up after this many instructions
    localparam int STEP_LIMIT = 4000;

    logic      clk = 1'b0;
    logic      reset;
    logic      loadEnable;
    memAddress loadAddress;
    dataWord   loadData;
    dataWord   outData;
    logic      outValid;
    logic      halted;

    // memory image as the DUT should hold it, plus the model's copy
    dataWord image [MEM_DEPTH];
    dataWord modelMem [MEM_DEPTH];
    dataWord progWords [$];
    dataWord expQueue [$];
    int      expCount;
    logic    modelHalt;

    // compare process state, cleared while checking is off
    logic checking;
    int   outCount;
    logic sawHalt;

    int valueErrors = 0;
    int strobeErrors = 0;
    int levelErrors = 0;
    int countErrors = 0;
    int runLimit;
    // watchdog budget in cycles, grows with every reset and run
    int budget = 0;
    int cycleCount = 0;

    microCpu #(
        .MEM_DEPTH (MEM_DEPTH),
        .REG_COUNT (REG_COUNT)
    ) microCpu_inst (
        .clk         (clk),
        .reset       (reset),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .outData     (outData),
        .outValid    (outValid),
        .halted      (halted)
    );

    always #20 clk = ~clk;

    // instruction-set model over the image
    // returns the number of instructions executed
    function automatic int executePrograms();
        memAddress pc;
        dataWord   regs [REG_COUNT];
        dataWord   ir;
        regIndex   rd;
        regIndex   rs;
        memAddress imm;
        int        steps;
        modelMem = image;
        for (int r = 0; r < REG_COUNT; r++) begin
            regs[r] = 16'h0000;
        end
        pc = 8'd0;
        steps = 0;
        modelHalt = 1'b0;
        expQueue.delete();
        while (!modelHalt && steps < STEP_LIMIT) begin
            ir = modelMem[pc];
            rd = ir[11:10];
            rs = ir[9:8];
            imm = ir[7:0];
            pc = pc + 8'd1;
            steps = steps + 1;
            case (ir[15:12])
                OP_LDI: regs[rd] = {8'h00, imm};
                OP_MOV: regs[rd] = regs[rs];
                // 16-bit wraparound comes from the word width
                OP_ADD: regs[rd] = regs[rd] + regs[rs];
                OP_SUB: regs[rd] = regs[rd] - regs[rs];
                OP_AND: regs[rd] = regs[rd] & regs[rs];
                OP_OR: regs[rd] = regs[rd] | regs[rs];
                OP_XOR: regs[rd] = regs[rd] ^ regs[rs];
                OP_LD: regs[rd] = modelMem[imm];
                OP_ST: modelMem[imm] = regs[rd];
                OP_BEQZ: begin
                    if (regs[rd] == 16'h0000) begin
                        pc = imm;
                    end
                end
                OP_JMP: pc = imm;
                OP_OUT: expQueue.push_back(regs[rd]);
                OP_HALT: modelHalt = 1'b1;
                // NOP and the two undefined codes
                default: ;
            endcase
        end
        expCount = expQueue.size();
        return steps;
    endfunction

    task automatic emit(input logic [3:0] code, input regIndex rd, input regIndex rs,
                        input memAddress imm);
        progWords.push_back({code, rd, rs, imm});
    endtask

    task automatic checkOutput(input dataWord got, input dataWord expected);
        if (got !== expected) begin
            $display("Error at %0t: output %0d is %h, expected %h", $time, outCount, got,
                     expected);
            valueErrors++;
        end
    endtask

    task automatic checkLevel(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, expected);
            levelErrors++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("Program %s gave %0d output strobes but the model expects %0d",
                     name, got, expected);
            countErrors++;
        end
    endtask

    // raise reset, load the first words of the image, hold 10 more cycles
    // reset stays high on return
    task automatic resetWithLoad(input int loadCount);
        reset = 1'b1;
        checking = 1'b0;
        budget += 200 + loadCount;
        for (int a = 0; a < loadCount; a++) begin
            loadEnable = 1'b1;
            loadAddress = memAddress'(a);
            loadData = image[a];
            @(posedge clk);
            #2;
        end
        loadEnable = 1'b0;
        repeat (10) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic launchRun();
        int steps;
        steps = executePrograms();
        runLimit = 5 * steps + 20;
        budget += 5 * steps;
        reset = 1'b0;
        checking = 1'b1;
    endtask

    task automatic awaitHalt(input string name);
        int waited;
        waited = 0;
        while (halted !== 1'b1 && waited < runLimit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        checkLevel("halted", halted, modelHalt);
        // halted must stay up, stray strobes are caught by the compare process
        repeat (8) begin
            @(posedge clk);
            #2;
            checkLevel("halted", halted, modelHalt);
        end
        checkCount(name, outCount, expCount);
        // stores are now in the DUT memory too
        image = modelMem;
    endtask

    task automatic runTest(input string name, input logic fullLoad);
        int loadCount;
        for (int a = 0; a < progWords.size(); a++) begin
            image[a] = progWords[a];
        end
        loadCount = fullLoad ? MEM_DEPTH : progWords.size();
        resetWithLoad(loadCount);
        launchRun();
        awaitHalt(name);
        progWords.delete();
    endtask

    // random body, then OUT of every register and HALT
    task automatic buildRandomProgram();
        int         total;
        int         bodyLen;
        int         span;
        logic [3:0] code;
        regIndex    rd;
        regIndex    rs;
        memAddress  imm;
        total = 20 + int'($urandom % 21);
        bodyLen = total - 5;
        for (int i = 0; i < bodyLen; i++) begin
            code = 4'($urandom % 16);
            rd = 2'($urandom % 4);
            rs = 2'($urandom % 4);
            imm = 8'($urandom % 256);
            if (code == OP_HALT) begin
                code = OP_OUT;
            end
            // forward targets only, up to the final HALT, so every run ends
            if (code == OP_BEQZ || code == OP_JMP) begin
                span = bodyLen + 4 - i;
                imm = 8'(i + 1 + int'($urandom % span));
            end
            // keep stores in the upper half, clear of the program
            if (code == OP_ST) begin
                imm = 8'h80 | imm;
            end
            emit(code, rd, rs, imm);
        end
        for (int r = 0; r < REG_COUNT; r++) begin
            emit(OP_OUT, 2'(r), 2'd0, 8'd0);
        end
        emit(OP_HALT, 2'd0, 2'd0, 8'd0);
    endtask

    // compare process, samples on the falling edge
    always @(negedge clk) begin
        if (!checking) begin
            outCount = 0;
            sawHalt = 1'b0;
        end else begin
            if (outValid === 1'b1) begin
                outCount = outCount + 1;
                if (sawHalt) begin
                    $display("Output strobe seen at %0t after the CPU halted", $time);
                    strobeErrors++;
                end else if (expQueue.size() == 0) begin
                    $display("Unexpected output strobe at %0t, no output left to expect",
                             $time);
                    strobeErrors++;
                end else begin
                    checkOutput(outData, expQueue.pop_front());
                end
            end
            if (halted === 1'b1) begin
                sawHalt = 1'b1;
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > budget) begin
            $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
                     cycleCount);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin : mainSequence
        int waited;
        void'($urandom(52));
        reset = 1'b1;
        loadEnable = 1'b0;
        loadAddress = 8'd0;
        loadData = 16'h0000;
        checking = 1'b0;
        // fill pattern, unique per address
        for (int a = 0; a < MEM_DEPTH; a++) begin
            image[a] = {memAddress'(a), ~memAddress'(a)};
        end

        // LDI, MOV and every ALU op, each shown by OUT
        emit(OP_LDI, 2'd0, 2'd0, 8'hF0);
        emit(OP_LDI, 2'd1, 2'd0, 8'h25);
        emit(OP_OUT, 2'd0, 2'd0, 8'd0);
        emit(OP_MOV, 2'd2, 2'd0, 8'd0);
        emit(OP_ADD, 2'd2, 2'd1, 8'd0);
        emit(OP_OUT, 2'd2, 2'd0, 8'd0);
        emit(OP_MOV, 2'd3, 2'd0, 8'd0);
        emit(OP_AND, 2'd3, 2'd1, 8'd0);
        emit(OP_OUT, 2'd3, 2'd0, 8'd0);
        emit(OP_MOV, 2'd3, 2'd0, 8'd0);
        emit(OP_OR, 2'd3, 2'd1, 8'd0);
        emit(OP_OUT, 2'd3, 2'd0, 8'd0);
        emit(OP_MOV, 2'd3, 2'd0, 8'd0);
        emit(OP_XOR, 2'd3, 2'd1, 8'd0);
        emit(OP_OUT, 2'd3, 2'd0, 8'd0);
        // 0 - 0x25 wraps below zero, then back over the top
        emit(OP_LDI, 2'd2, 2'd0, 8'h00);
        emit(OP_SUB, 2'd2, 2'd1, 8'd0);
        emit(OP_OUT, 2'd2, 2'd0, 8'd0);
        emit(OP_LDI, 2'd3, 2'd0, 8'h30);
        emit(OP_ADD, 2'd2, 2'd3, 8'd0);
        emit(OP_OUT, 2'd2, 2'd0, 8'd0);
        emit(OP_HALT, 2'd0, 2'd0, 8'd0);
        runTest("alu", 1'b1);

        // store then load into another register
        emit(OP_LDI, 2'd0, 2'd0, 8'h12);
        emit(OP_LDI, 2'd1, 2'd0, 8'h34);
        emit(OP_SUB, 2'd0, 2'd1, 8'd0);
        emit(OP_ST, 2'd0, 2'd0, 8'h90);
        emit(OP_LD, 2'd3, 2'd0, 8'h90);
        emit(OP_OUT, 2'd3, 2'd0, 8'd0);
        emit(OP_LD, 2'd2, 2'd0, 8'hA7);
        emit(OP_OUT, 2'd2, 2'd0, 8'd0);
        emit(OP_HALT, 2'd0, 2'd0, 8'd0);
        runTest("memory", 1'b0);

        // countdown from 5, branch taken only at zero
        emit(OP_LDI, 2'd0, 2'd0, 8'd5);
        emit(OP_LDI, 2'd1, 2'd0, 8'd1);
        emit(OP_BEQZ, 2'd0, 2'd0, 8'd6);
        emit(OP_OUT, 2'd0, 2'd0, 8'd0);
        emit(OP_SUB, 2'd0, 2'd1, 8'd0);
        emit(OP_JMP, 2'd0, 2'd0, 8'd2);
        emit(OP_OUT, 2'd0, 2'd0, 8'd0);
        emit(OP_HALT, 2'd0, 2'd0, 8'd0);
        runTest("countdown", 1'b0);

        // random programs, undefined opcodes included
        for (int n = 0; n < 6; n++) begin
            buildRandomProgram();
            runTest($sformatf("random %0d", n), 1'b0);
        end

        // countdown again, then reset after two outputs
        emit(OP_LDI, 2'd0, 2'd0, 8'd5);
        emit(OP_LDI, 2'd1, 2'd0, 8'd1);
        emit(OP_BEQZ, 2'd0, 2'd0, 8'd6);
        emit(OP_OUT, 2'd0, 2'd0, 8'd0);
        emit(OP_SUB, 2'd0, 2'd1, 8'd0);
        emit(OP_JMP, 2'd0, 2'd0, 8'd2);
        emit(OP_OUT, 2'd0, 2'd0, 8'd0);
        emit(OP_HALT, 2'd0, 2'd0, 8'd0);
        runTest("countdown reload", 1'b0);
        // halted is still up from that run, reset has to clear it
        resetWithLoad(0);
        checkLevel("halted", halted, 1'b0);
        launchRun();
        waited = 0;
        while (outCount < 2 && waited < runLimit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (outCount < 2) begin
            $display("Countdown gave fewer than two outputs before the mid-run reset");
            countErrors++;
        end
        resetWithLoad(0);
        checkLevel("outValid", outValid, 1'b0);
        // unchanged program, full sequence again from address 0
        launchRun();
        awaitHalt("countdown after mid-run reset");

        $display("Errors: %0d value, %0d strobe, %0d level, %0d count", valueErrors,
                 strobeErrors, levelErrors, countErrors);
        if (valueErrors + strobeErrors + levelErrors + countErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
